// File: axil_muldiv_regs.sv
`timescale 1ns/1ps

module axil_muldiv_regs import muldiv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              awvalid,
  output logic              awready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [XLEN-1:0]   wdata,
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  input  logic              arvalid,
  output logic              arready,
  input  logic [ADDR_W-1:0] araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [XLEN-1:0]   rdata,
  output logic [1:0]        rresp,
  output logic              start,
  output md_op_e            op,
  output logic [XLEN-1:0]   opa,
  output logic [XLEN-1:0]   opb,
  input  logic              busy,
  input  logic              done_pulse,
  input  logic [XLEN-1:0]   result
);

  logic wr_en;
  logic rd_en;
  logic done;

  // AW and W taken together, one response outstanding
  assign wr_en = awvalid & wvalid & ~bvalid;
  assign awready = wr_en;
  assign wready = wr_en;
  assign bresp = RESP_OKAY;

  assign arready = ~rvalid;
  assign rd_en = arvalid & arready;
  assign rresp = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst) begin
      bvalid <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_en) begin
        bvalid <= 1'b1;
        if (awaddr == REG_CTRL) begin
          start <= wdata[CTRL_START_BIT];
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (awaddr)
        REG_OPA:  opa <= wdata;
        REG_OPB:  opb <= wdata;
        REG_CTRL: op <= md_op_e'(wdata[OP_W-1:0]);
        default: ;
      endcase
    end
  end

  // Sticky done, a new start wins
  always_ff @(posedge clk) begin
    if (!rst) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b0;
    end else if (done_pulse) begin
      done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      rvalid <= 1'b0;
    end else if (rd_en) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= '0;   // Unmapped reads
      case (araddr)
        REG_OPA:    rdata <= opa;
        REG_OPB:    rdata <= opb;
        REG_CTRL:   rdata[OP_W-1:0] <= op;
        REG_STATUS: begin
          rdata[STAT_BUSY_BIT] <= busy;
          rdata[STAT_DONE_BIT] <= done;
        end
        REG_RESULT: rdata <= result;
        default: ;
      endcase
    end
  end

endmodule

// File: int_divider.sv
`timescale 1ns/1ps

module int_divider import muldiv_pkg::*; (
  input logic   clk,
  input logic   rst,
  md_eng_if.eng eng
);

  div_reg_t r;
  div_reg_t rin;

  logic                 signed_op;
  logic                 opb_neg;
  logic [DIV_CNT_W-1:0] lz;
  logic [XLEN:0]        diff;
  logic [XLEN-1:0]      quot;
  logic [XLEN-1:0]      rem;

  function automatic logic [DIV_CNT_W-1:0] lead_zeros(input logic [XLEN-1:0] x);
    logic [DIV_CNT_W-1:0] n;
    logic                 found;
    n = '0;
    found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (x[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  always_comb begin
    rin = r;
    signed_op = (eng.op == DIV) || (eng.op == REM);
    opb_neg = signed_op & eng.opb[XLEN-1];
    lz = '0;
    diff = '0;
    // Sign fix-up of the finished magnitudes
    quot = r.q_neg ? -r.rq[XLEN-1:0] : r.rq[XLEN-1:0];
    rem = r.op1_neg ? -r.rq[2*XLEN-1:XLEN] : r.rq[2*XLEN-1:XLEN];
    eng.ready = 1'b0;
    eng.result = '0;

    case (r.counter)
      6'd0: begin
        if (eng.enable) begin
          rin.op = eng.op;
          rin.data1 = eng.opa;
          rin.op1_neg = signed_op & eng.opa[XLEN-1];
          rin.op1 = rin.op1_neg ? -eng.opa : eng.opa;
          rin.op2 = opb_neg ? -eng.opb : eng.opb;
          rin.q_neg = rin.op1_neg ^ opb_neg;
          rin.div_zero = (eng.opb == '0);
          rin.overflow = signed_op && (eng.opa == XLEN_MIN) && (&eng.opb);
          // Skip leading zeros of the dividend
          lz = lead_zeros(rin.op1);
          rin.rq = {{(XLEN+1){1'b0}}, rin.op1} << lz;
          rin.counter = lz + 1'b1;
          if (rin.div_zero || rin.overflow) begin
            rin.counter = DIV_LAST;
          end
        end
      end

      DIV_LAST: begin
        eng.ready = 1'b1;
        rin.counter = '0;
        if (r.op == DIV || r.op == DIVU) begin
          if (r.div_zero) begin
            eng.result = '1;
          end else if (r.overflow) begin
            eng.result = XLEN_MIN;
          end else begin
            eng.result = quot;
          end
        end else begin
          if (r.div_zero) begin
            eng.result = r.data1;   // Remainder is the dividend
          end else if (r.overflow) begin
            eng.result = '0;
          end else begin
            eng.result = rem;
          end
        end
      end

      default: begin
        // Shift left one and try the subtract
        diff = r.rq[2*XLEN-1:XLEN-1] - {1'b0, r.op2};
        if (!diff[XLEN]) begin
          rin.rq = {diff, r.rq[XLEN-2:0], 1'b1};
        end else begin
          rin.rq = {r.rq[2*XLEN-1:0], 1'b0};
        end
        rin.counter = r.counter + 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r <= div_reg_init;
    end else begin
      r <= rin;
    end
  end

endmodule

// File: int_multiplier.sv
`timescale 1ns/1ps

module int_multiplier import muldiv_pkg::*; (
  input logic   clk,
  input logic   rst,
  md_eng_if.eng eng
);

  logic signed [XLEN:0]     a_ext;
  logic signed [XLEN:0]     b_ext;
  logic signed [2*XLEN+1:0] prod_full;
  logic [2*XLEN-1:0]        prod_q;
  logic                     hi_q;
  logic                     ready_q;

  // MULHU treats both operands unsigned, MULHSU only opb
  always_comb begin
    a_ext = {(eng.op != MULHU) & eng.opa[XLEN-1], eng.opa};
    b_ext = {((eng.op == MUL) || (eng.op == MULH)) & eng.opb[XLEN-1], eng.opb};
  end

  assign prod_full = a_ext * b_ext;

  always_ff @(posedge clk) begin
    if (eng.enable) begin
      prod_q <= prod_full[2*XLEN-1:0];
      hi_q <= (eng.op != MUL);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= eng.enable;
    end
  end

  assign eng.ready = ready_q;
  assign eng.result = hi_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

endmodule

// File: muldiv.f
muldiv_pkg.sv
muldiv_if.sv
int_divider.sv
int_multiplier.sv
muldiv_unit.sv
axil_muldiv_regs.sv
muldiv_axil_top.sv
muldiv_props.sv
tb_muldiv.sv

// File: muldiv_axil_top.sv
`timescale 1ns/1ps

module muldiv_axil_top import muldiv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              awvalid,
  output logic              awready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [XLEN-1:0]   wdata,
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  input  logic              arvalid,
  output logic              arready,
  input  logic [ADDR_W-1:0] araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [XLEN-1:0]   rdata,
  output logic [1:0]        rresp
);

  logic            start;
  md_op_e          op;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic            busy;
  logic            done_pulse;
  logic [XLEN-1:0] result;

  axil_muldiv_regs u_axil_muldiv_regs (
    .clk(clk), .rst(rst),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .start(start), .op(op), .opa(opa), .opb(opb),
    .busy(busy), .done_pulse(done_pulse), .result(result)
  );

  muldiv_unit u_muldiv_unit (
    .clk(clk), .rst(rst), .start(start), .op(op), .opa(opa), .opb(opb),
    .busy(busy), .done_pulse(done_pulse), .result(result)
  );

endmodule

// File: muldiv_if.sv
`timescale 1ns/1ps

interface md_eng_if import muldiv_pkg::*; ();

  logic            enable;  // One-cycle start
  md_op_e          op;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb;
  logic [XLEN-1:0] result;
  logic            ready;   // One cycle, result valid

  modport disp (
    output enable,
    output op,
    output opa,
    output opb,
    input  result,
    input  ready
  );

  modport eng (
    input  enable,
    input  op,
    input  opa,
    input  opb,
    output result,
    output ready
  );

endinterface

// File: muldiv_pkg.sv
package muldiv_pkg;

  localparam int XLEN = 32;
  localparam int OP_W = 3;
  localparam int ADDR_W = 5;
  localparam int DIV_CNT_W = 6;

  // RISC-V funct3 encoding
  typedef enum logic [OP_W-1:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } md_op_e;

  // Register map, byte offsets
  localparam logic [ADDR_W-1:0] REG_OPA    = 5'h00;
  localparam logic [ADDR_W-1:0] REG_OPB    = 5'h04;
  localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08;
  localparam logic [ADDR_W-1:0] REG_STATUS = 5'h0C;
  localparam logic [ADDR_W-1:0] REG_RESULT = 5'h10;

  localparam int CTRL_START_BIT = 8;
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_DONE_BIT  = 1;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  localparam logic [XLEN-1:0] XLEN_MIN = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [DIV_CNT_W-1:0] DIV_LAST = 6'd33;

  typedef struct packed {
    logic [DIV_CNT_W-1:0] counter;
    logic [2*XLEN:0]      rq;       // Partial remainder : quotient
    logic [XLEN-1:0]      op1;      // Dividend magnitude
    logic [XLEN-1:0]      op2;      // Divisor magnitude
    logic [XLEN-1:0]      data1;    // Dividend as given
    md_op_e               op;
    logic                 q_neg;
    logic                 op1_neg;
    logic                 div_zero;
    logic                 overflow;
  } div_reg_t;

  localparam div_reg_t div_reg_init = '0;

endpackage

// File: muldiv_props.sv
`timescale 1ns/1ps

module muldiv_props (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic done_pulse,
  input logic mul_en,
  input logic mul_ready,
  input logic div_en,
  input logic div_ready
);

  // Dispatch only from idle, busy follows
  enable_idle: assert property (@(posedge clk) disable iff (!rst)
    (mul_en || div_en) |=> (busy && !$past(busy)))
    else $error("engine enabled while busy, or busy did not follow the enable");

  mul_ready_after_en: assert property (@(posedge clk) disable iff (!rst)
    mul_en |=> mul_ready)
    else $error("multiplier ready missing one cycle after enable");

  mul_ready_has_en: assert property (@(posedge clk) disable iff (!rst)
    mul_ready |-> $past(mul_en))
    else $error("multiplier ready without enable");

  div_ready_in_op: assert property (@(posedge clk) disable iff (!rst)
    div_ready |-> busy)
    else $error("divider ready outside a running operation");

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst)
    done_pulse |=> !done_pulse)
    else $error("done_pulse longer than one cycle");

endmodule

bind muldiv_unit muldiv_props u_muldiv_props (
  .clk(clk),
  .rst(rst),
  .busy(busy),
  .done_pulse(done_pulse),
  .mul_en(mul_if.enable),
  .mul_ready(mul_if.ready),
  .div_en(div_if.enable),
  .div_ready(div_if.ready)
);

// File: muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit import muldiv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  md_op_e          op,
  input  logic [XLEN-1:0] opa,
  input  logic [XLEN-1:0] opb,
  output logic            busy,
  output logic            done_pulse,
  output logic [XLEN-1:0] result
);

  md_eng_if mul_if ();
  md_eng_if div_if ();

  logic            go;
  logic            is_div;
  logic            div_sel;   // Engine of the running op
  logic            eng_ready;
  logic [XLEN-1:0] eng_result;

  assign go = start & ~busy;   // Start while busy is dropped
  assign is_div = op inside {DIV, DIVU, REM, REMU};

  assign mul_if.enable = go & ~is_div;
  assign mul_if.op = op;
  assign mul_if.opa = opa;
  assign mul_if.opb = opb;

  assign div_if.enable = go & is_div;
  assign div_if.op = op;
  assign div_if.opa = opa;
  assign div_if.opb = opb;

  assign eng_ready = div_sel ? div_if.ready : mul_if.ready;
  assign eng_result = div_sel ? div_if.result : mul_if.result;

  int_multiplier u_int_multiplier (.clk(clk), .rst(rst), .eng(mul_if.eng));
  int_divider u_int_divider (.clk(clk), .rst(rst), .eng(div_if.eng));

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      done_pulse <= 1'b0;
      div_sel <= 1'b0;
    end else begin
      done_pulse <= 1'b0;
      if (go) begin
        busy <= 1'b1;
        div_sel <= is_div;
      end else if (busy && eng_ready) begin
        busy <= 1'b0;
        done_pulse <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy && eng_ready) begin
      result <= eng_result;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the muldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_muldiv -f muldiv.f

out=$(./obj_dir/Vtb_muldiv 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// File: tb_muldiv.sv
`timescale 1ns/1ps

module tb_muldiv import muldiv_pkg::*; ();

  logic            clk;
  logic            rst;
  logic            awvalid;
  logic            awready;
  logic [ADDR_W-1:0] awaddr;
  logic            wvalid;
  logic            wready;
  logic [XLEN-1:0] wdata;
  logic            bvalid;
  logic            bready;
  logic [1:0]      bresp;
  logic            arvalid;
  logic            arready;
  logic [ADDR_W-1:0] araddr;
  logic            rvalid;
  logic            rready;
  logic [XLEN-1:0] rdata;
  logic [1:0]      rresp;

  md_op_e          op_tab[$];
  logic [XLEN-1:0] a_tab[$];
  logic [XLEN-1:0] b_tab[$];
  logic [XLEN-1:0] exp_tab[$];

  integer seed;
  int     cycles = 0;
  int     timeout_limit;
  int     n_ok = 0;
  int     n_fail = 0;

  muldiv_axil_top u_muldiv_axil_top (
    .clk(clk), .rst(rst),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (timeout_limit > 0 && cycles > timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Test failed");
      $finish;
    end
  end

  // Entered and left at 1 ns after a rising edge
  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    if (bresp !== 2'b00) begin   // OKAY
      $display("ERROR t=%0t bresp expected %h got %h", $time, 2'b00, bresp);
      n_fail++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
    araddr = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    if (rresp !== 2'b00) begin
      $display("ERROR t=%0t rresp expected %h got %h", $time, 2'b00, rresp);
      n_fail++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_done();
    logic [XLEN-1:0] st;
    st = '0;
    while (!st[STAT_DONE_BIT]) axil_read(REG_STATUS, st);
  endtask

  task automatic add_row(input md_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                         input logic [XLEN-1:0] e);
    op_tab.push_back(op);
    a_tab.push_back(a);
    b_tab.push_back(b);
    exp_tab.push_back(e);
  endtask

  function automatic logic [XLEN-1:0] ctrl_word(input md_op_e op);
    return {23'b0, 1'b1, 5'b0, op};   // Start in bit 8
  endfunction

  // RISC-V M-extension semantics
  function automatic logic [XLEN-1:0] model_result(input md_op_e op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    logic [63:0]        p;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] sq;
    logic signed [31:0] sr;
    logic [XLEN-1:0]    res;
    logic               ovf;
    sa = a;
    sb = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    sq = '0;
    sr = '0;
    if (b != '0 && !ovf) begin   // Signed, rounds toward zero
      sq = sa / sb;
      sr = sa % sb;
    end
    case (op)
      MULH:    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      MULHSU:  p = {{32{a[31]}}, a} * {32'b0, b};
      default: p = {32'b0, a} * {32'b0, b};
    endcase
    case (op)
      MUL:               res = p[31:0];
      MULH, MULHSU, MULHU: res = p[63:32];
      DIV:  res = (b == '0) ? '1 : (ovf ? 32'h8000_0000 : sq);
      DIVU: res = (b == '0) ? '1 : a / b;
      REM:  res = (b == '0) ? a : (ovf ? '0 : sr);
      default: res = (b == '0) ? a : a % b;
    endcase
    return res;
  endfunction

  task automatic check_result(input int idx, input string label, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t result expected %h got %h", $time, exp, got);
      n_fail++;
      $display("test %0d %s mismatch", idx, label);
    end else begin
      n_ok++;
      $display("test %0d %s ok", idx, label);
    end
  endtask

  initial begin
    md_op_e          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] got;
    int              t0;
    int              idx;
    seed = 32'h8b7b;
    rst = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b1;

    add_row(MUL,    32'h0000_0007, 32'hFFFF_FFFD, 32'hFFFF_FFEB);
    add_row(MUL,    32'h1234_5678, 32'h0000_0010, 32'h2345_6780);
    add_row(MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    add_row(MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
    add_row(MULHU,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    add_row(MULH,   32'hFFFF_FFFF, 32'h0000_0005, 32'hFFFF_FFFF);
    add_row(MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
    add_row(MULHSU, 32'hFFFF_FFFF, 32'h0000_0002, 32'hFFFF_FFFF);
    add_row(DIV,    32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFA);  // -20 / 3
    add_row(REM,    32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFE);
    add_row(DIV,    32'h0000_0014, 32'hFFFF_FFFD, 32'hFFFF_FFFA);  // 20 / -3
    add_row(REM,    32'h0000_0014, 32'hFFFF_FFFD, 32'h0000_0002);
    add_row(DIV,    32'hFFFF_FFF9, 32'hFFFF_FFFE, 32'h0000_0003);
    add_row(REM,    32'hFFFF_FFF9, 32'hFFFF_FFFE, 32'hFFFF_FFFF);
    add_row(DIVU,   32'hFFFF_FFEC, 32'h0000_0003, 32'h5555_554E);
    add_row(REMU,   32'hFFFF_FFEC, 32'h0000_0003, 32'h0000_0002);
    add_row(DIV,    32'h0000_0005, 32'h0000_0000, 32'hFFFF_FFFF);  // Divide by zero
    add_row(DIVU,   32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF);
    add_row(REM,    32'hFFFF_FFF0, 32'h0000_0000, 32'hFFFF_FFF0);
    add_row(REMU,   32'h0000_ABCD, 32'h0000_0000, 32'h0000_ABCD);
    add_row(DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);  // Overflow
    add_row(REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
    add_row(DIVU,   32'h0000_0000, 32'h0000_0007, 32'h0000_0000);
    add_row(REMU,   32'h0000_0001, 32'h0000_0007, 32'h0000_0001);
    add_row(DIV,    32'h0000_0001, 32'h0000_0001, 32'h0000_0001);
    add_row(REM,    32'h0000_0000, 32'hFFFF_FFFB, 32'h0000_0000);
    add_row(DIVU,   32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF);  // Longest run
    add_row(DIVU,   32'h0000_0064, 32'h0000_0007, 32'h0000_000E);
    add_row(REMU,   32'h0000_0064, 32'h0000_0007, 32'h0000_0002);

    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      op = md_op_e'(r[2:0]);
      a = $random(seed);
      b = $random(seed);
      a = a >> r[8:4];   // Vary the leading zero count
      if (r[9]) b = b >> 24;
      if (r[12:10] == 3'd0) b = '0;
      add_row(op, a, b, model_result(op, a, b));
    end
    // Two extra tests after the table
    timeout_limit = (op_tab.size() + 2) * 60 + 200;

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    @(posedge clk);
    #1;

    for (int i = 0; i < op_tab.size(); i++) begin
      axil_write(REG_OPA, a_tab[i]);
      axil_write(REG_OPB, b_tab[i]);
      axil_write(REG_CTRL, ctrl_word(op_tab[i]));
      t0 = cycles;
      wait_done();
      // 34 cycles of divider plus status read latency
      if ((op_tab[i] inside {DIV, DIVU, REM, REMU}) && (cycles - t0 > 38)) begin
        $display("test %0d: done took %0d cycles, beyond the divider bound", i, cycles - t0);
        n_fail++;
      end
      axil_read(REG_RESULT, got);
      check_result(i, $sformatf("%s a=%h b=%h", op_tab[i].name(), a_tab[i], b_tab[i]),
                   got, exp_tab[i]);
    end

    // Start while busy must be dropped
    idx = op_tab.size();
    axil_write(REG_OPA, 32'hFFFF_FFFF);
    axil_write(REG_OPB, 32'h0000_0007);
    axil_write(REG_CTRL, ctrl_word(DIVU));
    axil_read(REG_STATUS, r);
    if (!r[STAT_BUSY_BIT]) begin
      $display("test %0d: unit not busy right after start", idx);
      n_fail++;
    end
    axil_write(REG_OPB, 32'h0000_0001);
    axil_write(REG_CTRL, ctrl_word(MUL));
    wait_done();
    axil_read(REG_RESULT, got);
    check_result(idx, "start while busy", got, 32'h2492_4924);

    axil_read(5'h14, got);
    check_result(idx + 1, "unmapped read", got, '0);

    $display("Summary: %0d tests, %0d ok, %0d failed", idx + 2, n_ok, n_fail);
    if (n_fail == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
